// File: hw/io_map_pkg.sv
package io_map_pkg;

	localparam int IO_ADDR_W = 16;
	localparam int SEL_COUNT = 22;

	// Bit positions in the select vector
	localparam int
		SEL_IDE0       = 0,  SEL_IDE1       = 1,
		SEL_JOY        = 2,  SEL_FDD        = 3,
		SEL_DMA_MASTER = 4,  SEL_DMA_PAGE   = 5,
		SEL_DMA_SLAVE  = 6,  SEL_PIC_MASTER = 7,
		SEL_PIC_SLAVE  = 8,  SEL_PIT        = 9,
		SEL_PS2_IO     = 10, SEL_PS2_CTL    = 11,
		SEL_RTC        = 12, SEL_FM         = 13,
		SEL_SB         = 14, SEL_UART1      = 15,
		SEL_UART2      = 16, SEL_MPU        = 17,
		SEL_VGA_B      = 18, SEL_VGA_C      = 19,
		SEL_VGA_D      = 20, SEL_SYSCTL     = 21;

	// IDE channels have a task-file block and a separate control pair
	localparam logic [IO_ADDR_W-1:0]
		IDE0_BASE  = 16'h01F0, IDE0_CTL   = 16'h03F6,
		IDE1_BASE  = 16'h0170, IDE1_CTL   = 16'h0376,
		JOY_BASE   = 16'h0201, FDD_BASE   = 16'h03F0,
		DMA_MASTER_BASE = 16'h00C0, DMA_PAGE_BASE  = 16'h0080,
		DMA_SLAVE_BASE  = 16'h0000, PIC_MASTER_BASE = 16'h0020,
		PIC_SLAVE_BASE  = 16'h00A0, PIT_BASE   = 16'h0040,
		PIT_PORT_B = 16'h0061, PS2_IO_BASE = 16'h0060,
		PS2_CTL_BASE = 16'h0090, RTC_BASE  = 16'h0070,
		FM_BASE    = 16'h0388, SB_BASE    = 16'h0220,
		UART1_BASE = 16'h03F8, UART2_BASE = 16'h02F8,
		MPU_BASE   = 16'h0330, VGA_B_BASE = 16'h03B0,
		VGA_C_BASE = 16'h03C0, VGA_D_BASE = 16'h03D0,
		SYSCTL_BASE = 16'h8888;

	// Low address bits ignored by each range
	localparam int
		IDE0_LOW = 3, IDE0_CTL_LOW = 1,
		IDE1_LOW = 3, IDE1_CTL_LOW = 1,
		JOY_LOW = 0, FDD_LOW = 3,
		DMA_MASTER_LOW = 5, DMA_PAGE_LOW = 4,
		DMA_SLAVE_LOW = 4, PIC_MASTER_LOW = 1,
		PIC_SLAVE_LOW = 1, PIT_LOW = 2,
		PS2_IO_LOW = 3, PS2_CTL_LOW = 4,
		RTC_LOW = 1, FM_LOW = 2,
		SB_LOW = 4, UART1_LOW = 3,
		UART2_LOW = 3, MPU_LOW = 1,
		VGA_B_LOW = 4, VGA_C_LOW = 4,
		VGA_D_LOW = 4, SYSCTL_LOW = 0;

	// Splits the IDE control pair from the data ports
	localparam int IDE_CTL_BIT = 9;

endpackage

// File: hw/sys_cfg_pkg.sv
package sys_cfg_pkg;

	// Bus widths
	localparam int DATA_W = 32;
	localparam int BYTE_W = 8;
	localparam int SIZE_W = 3;

	// Data size codes
	localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;
	localparam int SIZE_DWORD_BIT = 2;

	// System control port
	localparam logic [BYTE_W-1:0] SYSCFG_RESET = 8'hA2;
	localparam logic [BYTE_W-1:0] SYSCFG_KEY   = 8'hA1;

	// Floating bus on unmapped ports
	localparam logic [BYTE_W-1:0] READ_IDLE = 8'hFF;

endpackage

// File: hw/io_sel_if.sv
interface io_sel_if
	import io_map_pkg::*, sys_cfg_pkg::*;
();

	// Bus cycle as seen by the port blocks
	logic [IO_ADDR_W-1:0] address;
	logic                 read;
	logic                 write;
	logic [SIZE_W-1:0]    datasize;
	logic [DATA_W-1:0]    writedata;

	// One registered select per port range
	logic [SEL_COUNT-1:0] sel;

	modport decoder (
		output address,
		output read,
		output write,
		output datasize,
		output writedata,
		output sel
	);

	modport ctl (
		input address,
		input read,
		input write,
		input datasize,
		input writedata,
		input sel
	);

	modport reader (
		input address,
		input read,
		input write,
		input datasize,
		input writedata,
		input sel
	);

endinterface

// File: hw/io_port_decoder.sv
module io_port_decoder
	import io_map_pkg::*, sys_cfg_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [IO_ADDR_W-1:0] bus_address,
	input  logic                 bus_read,
	input  logic                 bus_write,
	input  logic [SIZE_W-1:0]    bus_datasize,
	input  logic [DATA_W-1:0]    bus_writedata,
	io_sel_if.decoder            bus,
	output logic [SEL_COUNT-1:0] dev_sel
);

	logic [SEL_COUNT-1:0] hit;
	logic [SEL_COUNT-1:0] sel_q;

	function automatic logic in_range(
		input logic [IO_ADDR_W-1:0] addr,
		input logic [IO_ADDR_W-1:0] base,
		input int                   low
	);
		logic [IO_ADDR_W-1:0] mask;
		mask = {IO_ADDR_W{1'b1}} << low;
		return (addr & mask) == base;
	endfunction

	always_comb begin
		hit = '0;
		hit[SEL_IDE0] = in_range(bus_address, IDE0_BASE, IDE0_LOW) ||
			in_range(bus_address, IDE0_CTL, IDE0_CTL_LOW);
		hit[SEL_IDE1] = in_range(bus_address, IDE1_BASE, IDE1_LOW) ||
			in_range(bus_address, IDE1_CTL, IDE1_CTL_LOW);
		hit[SEL_JOY]        = in_range(bus_address, JOY_BASE, JOY_LOW);
		// Top of the floppy block belongs to the IDE0 control pair
		hit[SEL_FDD]        = in_range(bus_address, FDD_BASE, FDD_LOW) &&
			!in_range(bus_address, IDE0_CTL, IDE0_CTL_LOW);
		hit[SEL_DMA_MASTER] = in_range(bus_address, DMA_MASTER_BASE, DMA_MASTER_LOW);
		hit[SEL_DMA_PAGE]   = in_range(bus_address, DMA_PAGE_BASE, DMA_PAGE_LOW);
		hit[SEL_DMA_SLAVE]  = in_range(bus_address, DMA_SLAVE_BASE, DMA_SLAVE_LOW);
		hit[SEL_PIC_MASTER] = in_range(bus_address, PIC_MASTER_BASE, PIC_MASTER_LOW);
		hit[SEL_PIC_SLAVE]  = in_range(bus_address, PIC_SLAVE_BASE, PIC_SLAVE_LOW);
		// Speaker gate at port B belongs to the timer alone
		hit[SEL_PIT] = in_range(bus_address, PIT_BASE, PIT_LOW) ||
			(bus_address == PIT_PORT_B);
		hit[SEL_PS2_IO]  = in_range(bus_address, PS2_IO_BASE, PS2_IO_LOW) &&
			(bus_address != PIT_PORT_B);
		hit[SEL_PS2_CTL] = in_range(bus_address, PS2_CTL_BASE, PS2_CTL_LOW);
		hit[SEL_RTC]     = in_range(bus_address, RTC_BASE, RTC_LOW);
		hit[SEL_FM]      = in_range(bus_address, FM_BASE, FM_LOW);
		hit[SEL_SB]      = in_range(bus_address, SB_BASE, SB_LOW);
		hit[SEL_UART1]   = in_range(bus_address, UART1_BASE, UART1_LOW);
		hit[SEL_UART2]   = in_range(bus_address, UART2_BASE, UART2_LOW);
		hit[SEL_MPU]     = in_range(bus_address, MPU_BASE, MPU_LOW);
		hit[SEL_VGA_B]   = in_range(bus_address, VGA_B_BASE, VGA_B_LOW);
		hit[SEL_VGA_C]   = in_range(bus_address, VGA_C_BASE, VGA_C_LOW);
		hit[SEL_VGA_D]   = in_range(bus_address, VGA_D_BASE, VGA_D_LOW);
		hit[SEL_SYSCTL]  = in_range(bus_address, SYSCTL_BASE, SYSCTL_LOW);
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			sel_q <= '0;
		else
			sel_q <= hit;
	end

	assign dev_sel = sel_q;
	assign bus.sel = sel_q;

	assign bus.address   = bus_address;
	assign bus.read      = bus_read;
	assign bus.write     = bus_write;
	assign bus.datasize  = bus_datasize;
	assign bus.writedata = bus_writedata;

endmodule

// File: hw/sys_ctl_port.sv
module sys_ctl_port
	import io_map_pkg::*, sys_cfg_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	io_sel_if.ctl             bus,
	output logic [BYTE_W-1:0] syscfg
);

	logic first_access;
	logic disk_hit;
	logic key_write;

	assign disk_hit = bus.sel[SEL_IDE0] | bus.sel[SEL_IDE1] | bus.sel[SEL_FDD];

	// Word write with the key in the upper byte
	assign key_write = bus.write && bus.sel[SEL_SYSCTL] &&
		(bus.datasize == SIZE_WORD) &&
		(bus.writedata[2*BYTE_W-1:BYTE_W] == SYSCFG_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg       <= SYSCFG_RESET;
			first_access <= 1'b1;
		end else if (disk_hit && first_access) begin
			// Boot default is dropped once the OS touches a disk
			syscfg       <= '0;
			first_access <= 1'b0;
		end else if (key_write) begin
			syscfg       <= bus.writedata[BYTE_W-1:0];
			first_access <= 1'b0;
		end
	end

endmodule

// File: hw/io_read_path.sv
module io_read_path
	import io_map_pkg::*, sys_cfg_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	io_sel_if.reader          bus,
	input  logic [BYTE_W-1:0] fdd_readdata,
	input  logic [BYTE_W-1:0] dma_readdata,
	input  logic [BYTE_W-1:0] pic_readdata,
	input  logic [BYTE_W-1:0] pit_readdata,
	input  logic [BYTE_W-1:0] ps2_readdata,
	input  logic [BYTE_W-1:0] rtc_readdata,
	input  logic [BYTE_W-1:0] sound_readdata,
	input  logic [BYTE_W-1:0] uart1_readdata,
	input  logic [BYTE_W-1:0] uart2_readdata,
	input  logic [BYTE_W-1:0] mpu_readdata,
	input  logic [BYTE_W-1:0] vga_readdata,
	input  logic [BYTE_W-1:0] joy_readdata,
	input  logic [DATA_W-1:0] ide0_readdata,
	input  logic [DATA_W-1:0] ide1_readdata,
	input  logic              ide0_nodata,
	input  logic              ide1_nodata,
	output logic [DATA_W-1:0] bus_readdata,
	output logic              bus_io32,
	output logic              bus_wait,
	output logic              ide0_read,
	output logic              ide1_read
);

	logic [SEL_COUNT-1:0] s;
	logic [BYTE_W-1:0]    byte_data;
	logic                 ide_reg_zero;
	logic [1:0]           ide_sel;
	logic [1:0]           ide_nodata;
	logic [1:0]           ide_wait;

	assign s = bus.sel;

	always_comb begin
		if (s[SEL_FDD])
			byte_data = fdd_readdata;
		else if (s[SEL_DMA_MASTER] || s[SEL_DMA_SLAVE] || s[SEL_DMA_PAGE])
			byte_data = dma_readdata;
		else if (s[SEL_PIC_MASTER] || s[SEL_PIC_SLAVE])
			byte_data = pic_readdata;
		else if (s[SEL_PIT])
			byte_data = pit_readdata;
		else if (s[SEL_PS2_IO] || s[SEL_PS2_CTL])
			byte_data = ps2_readdata;
		else if (s[SEL_RTC])
			byte_data = rtc_readdata;
		else if (s[SEL_SB] || s[SEL_FM])
			byte_data = sound_readdata;
		else if (s[SEL_UART1])
			byte_data = uart1_readdata;
		else if (s[SEL_UART2])
			byte_data = uart2_readdata;
		else if (s[SEL_MPU])
			byte_data = mpu_readdata;
		else if (s[SEL_VGA_B] || s[SEL_VGA_C] || s[SEL_VGA_D])
			byte_data = vga_readdata;
		else if (s[SEL_JOY])
			byte_data = joy_readdata;
		else
			byte_data = READ_IDLE;
	end

	// IDE words win over every byte source
	assign bus_readdata = s[SEL_IDE0] ? ide0_readdata :
		s[SEL_IDE1] ? ide1_readdata :
		{{(DATA_W-BYTE_W){1'b0}}, byte_data};

	assign bus_io32 = ((s[SEL_IDE0] | s[SEL_IDE1]) & ~bus.address[IDE_CTL_BIT]) |
		s[SEL_SYSCTL];

	// Data register of the task file
	assign ide_reg_zero = !bus.address[IDE_CTL_BIT] && (bus.address[IDE0_LOW-1:0] == '0);

	assign ide_sel    = {s[SEL_IDE1], s[SEL_IDE0]};
	assign ide_nodata = {ide1_nodata, ide0_nodata};

	// Hold the read open until the drive has data
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < 2; i++) begin
			if (reset || !ide_nodata[i])
				ide_wait[i] <= 1'b0;
			else if (bus.read && ide_sel[i] && ide_reg_zero)
				ide_wait[i] <= 1'b1;
		end
	end

	assign bus_wait  = |ide_wait;
	assign ide0_read = (bus.read & ide_sel[0]) | ide_wait[0];
	assign ide1_read = (bus.read & ide_sel[1]) | ide_wait[1];

endmodule

// File: hw/isa_io_fabric.sv
module isa_io_fabric
	import io_map_pkg::*, sys_cfg_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [IO_ADDR_W-1:0] bus_address,
	input  logic                 bus_read,
	input  logic                 bus_write,
	input  logic [SIZE_W-1:0]    bus_datasize,
	input  logic [DATA_W-1:0]    bus_writedata,
	input  logic [BYTE_W-1:0]    fdd_readdata,
	input  logic [BYTE_W-1:0]    dma_readdata,
	input  logic [BYTE_W-1:0]    pic_readdata,
	input  logic [BYTE_W-1:0]    pit_readdata,
	input  logic [BYTE_W-1:0]    ps2_readdata,
	input  logic [BYTE_W-1:0]    rtc_readdata,
	input  logic [BYTE_W-1:0]    sound_readdata,
	input  logic [BYTE_W-1:0]    uart1_readdata,
	input  logic [BYTE_W-1:0]    uart2_readdata,
	input  logic [BYTE_W-1:0]    mpu_readdata,
	input  logic [BYTE_W-1:0]    vga_readdata,
	input  logic [BYTE_W-1:0]    joy_readdata,
	input  logic [DATA_W-1:0]    ide0_readdata,
	input  logic [DATA_W-1:0]    ide1_readdata,
	input  logic                 ide0_nodata,
	input  logic                 ide1_nodata,
	output logic [SEL_COUNT-1:0] dev_sel,
	output logic [DATA_W-1:0]    bus_readdata,
	output logic                 bus_io32,
	output logic                 bus_wait,
	output logic                 ide0_read,
	output logic                 ide1_read,
	output logic [BYTE_W-1:0]    syscfg
);

	io_sel_if io_bus ();

	io_port_decoder decoder (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus_address   (bus_address),
		.bus_read      (bus_read),
		.bus_write     (bus_write),
		.bus_datasize  (bus_datasize),
		.bus_writedata (bus_writedata),
		.bus           (io_bus),
		.dev_sel       (dev_sel)
	);

	sys_ctl_port ctl_port (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (io_bus),
		.syscfg  (syscfg)
	);

	io_read_path read_path (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.bus            (io_bus),
		.fdd_readdata   (fdd_readdata),
		.dma_readdata   (dma_readdata),
		.pic_readdata   (pic_readdata),
		.pit_readdata   (pit_readdata),
		.ps2_readdata   (ps2_readdata),
		.rtc_readdata   (rtc_readdata),
		.sound_readdata (sound_readdata),
		.uart1_readdata (uart1_readdata),
		.uart2_readdata (uart2_readdata),
		.mpu_readdata   (mpu_readdata),
		.vga_readdata   (vga_readdata),
		.joy_readdata   (joy_readdata),
		.ide0_readdata  (ide0_readdata),
		.ide1_readdata  (ide1_readdata),
		.ide0_nodata    (ide0_nodata),
		.ide1_nodata    (ide1_nodata),
		.bus_readdata   (bus_readdata),
		.bus_io32       (bus_io32),
		.bus_wait       (bus_wait),
		.ide0_read      (ide0_read),
		.ide1_read      (ide1_read)
	);

endmodule

// File: dv/io_fabric_checker.sv
module io_fabric_checker
	import io_map_pkg::*;
(
	input logic                 clk_sys,
	input logic                 reset,
	input logic [SEL_COUNT-1:0] sel,
	input logic [1:0]           stall,
	input logic [1:0]           nodata,
	input logic                 bus_wait,
	input logic                 ide0_read,
	input logic                 ide1_read
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0;

	sel_onehot: assert property (@(posedge clk_sys) disable iff (reset) $onehot0(sel))
		else begin
			$error("more than one port range selected: %b", sel);
			fail_count++;
		end

	wait_after_reset: assert property (@(posedge clk_sys) $fell(reset) |-> !bus_wait)
		else begin
			$error("bus_wait high in the cycle after reset");
			fail_count++;
		end

	read_held0: assert property (@(posedge clk_sys) disable iff (reset) stall[0] |-> ide0_read)
		else begin
			$error("ide0_read low during an IDE0 stall");
			fail_count++;
		end

	read_held1: assert property (@(posedge clk_sys) disable iff (reset) stall[1] |-> ide1_read)
		else begin
			$error("ide1_read low during an IDE1 stall");
			fail_count++;
		end

	stall_end0: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nodata[0]) |=> !stall[0])
		else begin
			$error("IDE0 stall did not end after nodata fell");
			fail_count++;
		end

	stall_end1: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nodata[1]) |=> !stall[1])
		else begin
			$error("IDE1 stall did not end after nodata fell");
			fail_count++;
		end

endmodule

bind io_read_path io_fabric_checker chk0 (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.sel       (s),
	.stall     (ide_wait),
	.nodata    (ide_nodata),
	.bus_wait  (bus_wait),
	.ide0_read (ide0_read),
	.ide1_read (ide1_read)
);

// File: dv/isa_io_fabric_tb.sv
module isa_io_fabric_tb
	import io_map_pkg::*, sys_cfg_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ADDR   = 24;
	localparam int SRC_IDE0 = 12;
	localparam int SRC_IDE1 = 13;
	localparam int SRC_IDLE = 14;

	logic                 clk_sys;
	logic                 reset;
	logic [IO_ADDR_W-1:0] bus_address;
	logic                 bus_read;
	logic                 bus_write;
	logic [SIZE_W-1:0]    bus_datasize;
	logic [DATA_W-1:0]    bus_writedata;
	logic [BYTE_W-1:0]    src_byte [12];
	logic [DATA_W-1:0]    ide_word [2];
	logic [1:0]           nodata;
	logic [SEL_COUNT-1:0] dev_sel;
	logic [DATA_W-1:0]    bus_readdata;
	logic                 bus_io32;
	logic                 bus_wait;
	logic [1:0]           ide_rd;
	logic [BYTE_W-1:0]    syscfg;

	int seed = 51;
	int errors = 0;
	int tests = 0;

	// One address per range, the select it hits and the source it reads
	logic [IO_ADDR_W-1:0] addr_tab [N_ADDR] = '{
		16'h01F0, 16'h03F6, 16'h0170, 16'h0201, 16'h03F0, 16'h00C0, 16'h0080, 16'h0000,
		16'h0020, 16'h00A0, 16'h0040, 16'h0061, 16'h0060, 16'h0090, 16'h0070, 16'h0388,
		16'h0220, 16'h03F8, 16'h02F8, 16'h0330, 16'h03B0, 16'h03C0, 16'h03D0, 16'h8888};
	int sel_tab [N_ADDR] = '{
		SEL_IDE0, SEL_IDE0, SEL_IDE1, SEL_JOY, SEL_FDD, SEL_DMA_MASTER, SEL_DMA_PAGE,
		SEL_DMA_SLAVE, SEL_PIC_MASTER, SEL_PIC_SLAVE, SEL_PIT, SEL_PIT, SEL_PS2_IO,
		SEL_PS2_CTL, SEL_RTC, SEL_FM, SEL_SB, SEL_UART1, SEL_UART2, SEL_MPU, SEL_VGA_B,
		SEL_VGA_C, SEL_VGA_D, SEL_SYSCTL};
	// Byte sources: fdd dma pic pit ps2 rtc sound uart1 uart2 mpu vga joy
	int src_tab [N_ADDR] = '{
		12, 12, 13, 11, 0, 1, 1, 1, 2, 2, 3, 3, 4, 4, 5, 6, 6, 7, 8, 9, 10, 10, 10, 14};

	isa_io_fabric dut0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.bus_address    (bus_address),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_datasize   (bus_datasize),
		.bus_writedata  (bus_writedata),
		.fdd_readdata   (src_byte[0]),
		.dma_readdata   (src_byte[1]),
		.pic_readdata   (src_byte[2]),
		.pit_readdata   (src_byte[3]),
		.ps2_readdata   (src_byte[4]),
		.rtc_readdata   (src_byte[5]),
		.sound_readdata (src_byte[6]),
		.uart1_readdata (src_byte[7]),
		.uart2_readdata (src_byte[8]),
		.mpu_readdata   (src_byte[9]),
		.vga_readdata   (src_byte[10]),
		.joy_readdata   (src_byte[11]),
		.ide0_readdata  (ide_word[0]),
		.ide1_readdata  (ide_word[1]),
		.ide0_nodata    (nodata[0]),
		.ide1_nodata    (nodata[1]),
		.dev_sel        (dev_sel),
		.bus_readdata   (bus_readdata),
		.bus_io32       (bus_io32),
		.bus_wait       (bus_wait),
		.ide0_read      (ide_rd[0]),
		.ide1_read      (ide_rd[1]),
		.syscfg         (syscfg)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic check_value(input string test, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		assert (act === exp)
		else begin
			$display("mismatch in %s: expected %h, actual %h", test, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string test, input int start);
		tests++;
		$display("%s finished with %0d errors", test, errors - start);
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		#1 reset = 1'b1;
		bus_address = 16'h0300;
		repeat (8) @(posedge clk_sys);
		#1 reset = 1'b0;
	endtask

	// Select is valid one clock after the address
	task automatic set_address(input logic [IO_ADDR_W-1:0] addr);
		@(posedge clk_sys);
		#1 bus_address = addr;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic write_cycle(input logic [IO_ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size,
		input logic [DATA_W-1:0] data);
		set_address(addr);
		bus_datasize = size;
		bus_writedata = data;
		bus_write = 1'b1;
		@(posedge clk_sys);
		#1 bus_write = 1'b0;
	endtask

	task automatic read_pulse();
		bus_read = 1'b1;
		@(posedge clk_sys);
		#1 bus_read = 1'b0;
	endtask

	// Distinct bytes, none equal to the idle value
	task automatic fill_sources();
		logic [BYTE_W-1:0] b;
		logic              dup;
		for (int i = 0; i < 12; i++) begin
			do begin
				b = BYTE_W'($random(seed));
				dup = (b == 8'hFF);
				for (int j = 0; j < i; j++)
					if (src_byte[j] == b)
						dup = 1'b1;
			end while (dup);
			src_byte[i] = b;
		end
		ide_word[0] = $random(seed);
		ide_word[1] = $random(seed);
	endtask

	task automatic test_ctl_write();
		int start;
		start = errors;
		check_value("ctl_write", 32'hA2, DATA_W'(syscfg));
		write_cycle(16'h8888, 3'd2, 32'h0000_A05C);
		check_value("ctl_write", 32'hA2, DATA_W'(syscfg));
		write_cycle(16'h8888, 3'd4, 32'h0000_A15C);
		check_value("ctl_write", 32'hA2, DATA_W'(syscfg));
		write_cycle(16'h8888, 3'd2, 32'h0000_A15C);
		check_value("ctl_write", 32'h5C, DATA_W'(syscfg));
		end_test("ctl_write", start);
	endtask

	task automatic test_first_access();
		int start;
		start = errors;
		apply_reset();
		check_value("first_access", 32'hA2, DATA_W'(syscfg));
		set_address(16'h01F0);
		@(posedge clk_sys);
		#1;
		check_value("first_access", 32'h00, DATA_W'(syscfg));
		apply_reset();
		write_cycle(16'h8888, 3'd2, 32'h0000_A133);
		check_value("first_access", 32'h33, DATA_W'(syscfg));
		set_address(16'h03F0);
		@(posedge clk_sys);
		#1;
		check_value("first_access", 32'h33, DATA_W'(syscfg));
		end_test("first_access", start);
	endtask

	task automatic test_decode();
		int                   start;
		logic [SEL_COUNT-1:0] exp;
		start = errors;
		for (int i = 0; i < N_ADDR; i++) begin
			set_address(addr_tab[i]);
			exp = '0;
			exp[sel_tab[i]] = 1'b1;
			check_value("decode", DATA_W'(exp), DATA_W'(dev_sel));
		end
		set_address(16'h0300);
		check_value("decode", 32'h0, DATA_W'(dev_sel));
		check_value("decode", 32'hFF, bus_readdata);
		end_test("decode", start);
	endtask

	task automatic test_read_mux();
		int                start;
		logic [DATA_W-1:0] exp;
		logic              exp_io32;
		start = errors;
		for (int i = 0; i < N_ADDR; i++) begin
			set_address(addr_tab[i]);
			case (src_tab[i])
				SRC_IDE0: exp = ide_word[0];
				SRC_IDE1: exp = ide_word[1];
				SRC_IDLE: exp = 32'hFF;
				default:  exp = DATA_W'(src_byte[src_tab[i]]);
			endcase
			check_value("read_mux", exp, bus_readdata);
			// IDE data block and control port are 32 bits wide
			exp_io32 = ((sel_tab[i] == SEL_IDE0 || sel_tab[i] == SEL_IDE1) &&
				!addr_tab[i][9]) || sel_tab[i] == SEL_SYSCTL;
			check_value("read_mux_io32", DATA_W'(exp_io32), DATA_W'(bus_io32));
		end
		end_test("read_mux", start);
	endtask

	task automatic test_ide_stall(input int ch);
		int                   start;
		int                   cycles;
		logic [IO_ADDR_W-1:0] base;
		string                name;
		start = errors;
		base = (ch == 0) ? 16'h01F0 : 16'h0170;
		name = (ch == 0) ? "ide0_stall" : "ide1_stall";
		set_address(base);
		nodata[ch] = 1'b1;
		read_pulse();
		repeat (3) begin
			@(posedge clk_sys);
			#1;
			check_value(name, 32'd1, DATA_W'(bus_wait));
			check_value(name, 32'd1, DATA_W'(ide_rd[ch]));
		end
		nodata[ch] = 1'b0;
		cycles = 0;
		do begin
			@(posedge clk_sys);
			#1;
			cycles++;
		end while (bus_wait && cycles < 16);
		assert (!bus_wait)
		else begin
			$display("%s: bus_wait still high %0d cycles after nodata fell", name, cycles);
			errors++;
		end
		check_value(name, 32'd0, DATA_W'(ide_rd[ch]));
		// Only the data register stalls
		set_address(base + 16'd1);
		nodata[ch] = 1'b1;
		read_pulse();
		repeat (3) begin
			@(posedge clk_sys);
			#1;
			check_value(name, 32'd0, DATA_W'(bus_wait));
		end
		nodata[ch] = 1'b0;
		end_test(name, start);
	endtask

	initial begin
		reset = 1'b1;
		bus_address = 16'h0300;
		bus_read = 1'b0;
		bus_write = 1'b0;
		bus_datasize = '0;
		bus_writedata = '0;
		nodata = '0;
		fill_sources();
		apply_reset();
		test_ctl_write();
		test_first_access();
		test_decode();
		test_read_mux();
		test_ide_stall(0);
		test_ide_stall(1);
		errors += dut0.read_path.chk0.fail_count;
		$display("tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: filelist.f
hw/io_map_pkg.sv
hw/sys_cfg_pkg.sv
hw/io_sel_if.sv
hw/io_port_decoder.sv
hw/sys_ctl_port.sv
hw/io_read_path.sv
hw/isa_io_fabric.sv
dv/io_fabric_checker.sv
dv/isa_io_fabric_tb.sv

// File: Bender.yml
package:
  name: isa_io_fabric

sources:
  - hw/io_map_pkg.sv
  - hw/sys_cfg_pkg.sv
  - hw/io_sel_if.sv
  - hw/io_port_decoder.sv
  - hw/sys_ctl_port.sv
  - hw/io_read_path.sv
  - hw/isa_io_fabric.sv
  - target: test
    files:
      - dv/io_fabric_checker.sv
      - dv/isa_io_fabric_tb.sv
